// ==== common/gtlink_cfg.svh ====
`ifndef GTLINK_CFG_SVH
`define GTLINK_CFG_SVH

// lane count, one independent channel per lane
`define GTLINK_LANES 2

// K28.5 with negative running disparity, bit 0 is the first bit on the line
`define GTLINK_COMMA 10'h17c
`define GTLINK_K28_5 8'hbc

`define GTLINK_WAIT_PLL 2
`define GTLINK_WAIT_GT 100
`define GTLINK_TIMEOUT 2000

`endif

// ==== common/gtlink_pkg.sv ====
`default_nettype none

package gtlink_pkg;

	typedef struct packed {
		logic        valid;
		logic [1:0]  isk;   // one flag per byte
		logic [15:0] data;
	} lane_word_t;

	typedef logic [19:0] symbol_t; // low byte symbol in [9:0]

	typedef struct packed {
		logic aligned;
		logic disp_err;
		logic code_err;
	} lane_status_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_START,
		PLL_RESET,
		PLL_WAIT,
		GT_RESET,
		GT_WAIT,
		DATA
	} seq_state_e;

	// 5b/6b, {flip at rd+, abcdei at rd-}
	function automatic logic [6:0] code6_tab(input logic [4:0] x);
		case (x)
			5'd0:  return 7'b1_100111;
			5'd1:  return 7'b1_011101;
			5'd2:  return 7'b1_101101;
			5'd3:  return 7'b0_110001;
			5'd4:  return 7'b1_110101;
			5'd5:  return 7'b0_101001;
			5'd6:  return 7'b0_011001;
			5'd7:  return 7'b1_111000; // balanced but still flips
			5'd8:  return 7'b1_111001;
			5'd9:  return 7'b0_100101;
			5'd10: return 7'b0_010101;
			5'd11: return 7'b0_110100;
			5'd12: return 7'b0_001101;
			5'd13: return 7'b0_101100;
			5'd14: return 7'b0_011100;
			5'd15: return 7'b1_010111;
			5'd16: return 7'b1_011011;
			5'd17: return 7'b0_100011;
			5'd18: return 7'b0_010011;
			5'd19: return 7'b0_110010;
			5'd20: return 7'b0_001011;
			5'd21: return 7'b0_101010;
			5'd22: return 7'b0_011010;
			5'd23: return 7'b1_111010;
			5'd24: return 7'b1_110011;
			5'd25: return 7'b0_100110;
			5'd26: return 7'b0_010110;
			5'd27: return 7'b1_110110;
			5'd28: return 7'b0_001110;
			5'd29: return 7'b1_101110;
			5'd30: return 7'b1_011110;
			default: return 7'b1_101011;
		endcase
	endfunction

	// 3b/4b data codes, {flip at rd+, fghj at rd-}
	function automatic logic [4:0] code4_tab(input logic [2:0] y);
		case (y)
			3'd0: return 5'b1_1011;
			3'd1: return 5'b0_1001;
			3'd2: return 5'b0_0101;
			3'd3: return 5'b1_1100;
			3'd4: return 5'b1_1101;
			3'd5: return 5'b0_1010;
			3'd6: return 5'b0_0110;
			default: return 5'b1_1110;
		endcase
	endfunction

	// K28.y fghj at rd-, whole symbol is inverted at rd+
	function automatic logic [3:0] code4_k(input logic [2:0] y);
		case (y)
			3'd0: return 4'b0100;
			3'd1: return 4'b1001;
			3'd2: return 4'b0101;
			3'd3: return 4'b0011;
			3'd4: return 4'b0010;
			3'd5: return 4'b1010;
			3'd6: return 4'b0110;
			default: return 4'b1000;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== lane/enc_8b10b.sv ====
`timescale 1ns/10ps
`default_nettype none

module enc_8b10b import gtlink_pkg::*; (
	input  wire [7:0] din,
	input  wire       isk,
	input  wire       rd_in,  // 1 is positive
	output logic [9:0] dout,
	output logic      rd_out
);

	logic [6:0] c6;
	logic [4:0] c4;
	logic [5:0] b6;
	logic [3:0] b4;
	logic [9:0] code; // abcdei fghj, a in msb
	logic rd6;
	logic alt7;

	always_comb begin
		c6 = code6_tab(din[4:0]);
		c4 = code4_tab(din[7:5]);
		b6 = c6[5:0];
		if (rd_in && c6[6])
			b6 = ~b6;
		rd6 = ($countones(b6) == 3) ? rd_in : ($countones(b6) > 3);
		// x.7 alternate keeps runs of five equal bits out of the stream
		alt7 = (din[7:5] == 3'd7) &&
			((!rd6 && (din[4:0] == 5'd17 || din[4:0] == 5'd18 || din[4:0] == 5'd20)) ||
			(rd6 && (din[4:0] == 5'd11 || din[4:0] == 5'd13 || din[4:0] == 5'd14)));
		b4 = alt7 ? 4'b0111 : c4[3:0];
		if (rd6 && (c4[4] || alt7))
			b4 = ~b4;
		code = {b6, b4};
		if (isk) begin // K28 only
			code = {6'b001111, code4_k(din[7:5])};
			if (rd_in)
				code = ~code;
		end
		for (int i = 0; i < 10; i++)
			dout[i] = code[9-i];
		rd_out = ($countones(code) == 5) ? rd_in : ($countones(code) > 5);
	end

endmodule

`default_nettype wire

// ==== lane/dec_8b10b.sv ====
`timescale 1ns/10ps
`default_nettype none

module dec_8b10b import gtlink_pkg::*; (
	input  wire [9:0] din,
	input  wire       rd_in,
	output logic [7:0] dout,
	output logic      isk,
	output logic      rd_out,
	output logic      disp_err,
	output logic      code_err
);

	logic [9:0] code;
	logic [5:0] b6;
	logic [3:0] b4;
	logic [6:0] t6;
	logic [4:0] t4;
	logic [4:0] x;
	logic [2:0] y;
	logic hit6, hit4, minus6, plus6, minus4, plus4, rd6;

	always_comb begin
		for (int i = 0; i < 10; i++)
			code[9-i] = din[i];
		b6 = code[9:4];
		b4 = code[3:0];
		{hit6, minus6, plus6, x} = '0;
		for (int i = 0; i < 32; i++) begin
			t6 = code6_tab(5'(i));
			if (b6 == t6[5:0]) begin
				{hit6, minus6, x} = {1'b1, t6[6], 5'(i)};
			end else if (t6[6] && b6 == ~t6[5:0]) begin
				{hit6, plus6, x} = {2'b11, 5'(i)};
			end
		end
		isk = (b6 == 6'b001111 || b6 == 6'b110000);
		if (isk)
			{hit6, minus6, plus6, x} = {1'b1, b6[0], !b6[0], 5'd28};
		rd6 = ($countones(b6) == 3) ? rd_in : ($countones(b6) > 3);
		{hit4, minus4, plus4, y} = '0;
		for (int j = 0; j < 8; j++) begin
			t4 = code4_tab(3'(j));
			if (isk) begin
				if (b4 == (plus6 ? ~code4_k(3'(j)) : code4_k(3'(j))))
					{hit4, y} = {1'b1, 3'(j)};
			end else if (b4 == t4[3:0]) begin
				{hit4, minus4, y} = {1'b1, t4[4], 3'(j)};
			end else if (t4[4] && b4 == ~t4[3:0]) begin
				{hit4, plus4, y} = {2'b11, 3'(j)};
			end
		end
		if (!isk && (b4 == 4'b0111 || b4 == 4'b1000)) // x.7 alternate
			{hit4, minus4, plus4, y} = {1'b1, b4[0], !b4[0], 3'd7};
		dout     = {y, x};
		code_err = !(hit6 && hit4);
		disp_err = (minus6 && rd_in) || (plus6 && !rd_in) || (minus4 && rd6) || (plus4 && !rd6);
		rd_out   = ($countones(din) == 5) ? rd_in : ($countones(din) > 5);
	end

endmodule

`default_nettype wire

// ==== lane/gt_lane.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module gt_lane import gtlink_pkg::*; (
	input  wire          TXUSRCLK,
	input  wire          sreset,
	input  lane_word_t   tx_word,
	output symbol_t      tx_sym,
	input  symbol_t      rx_sym,
	output lane_word_t   rx_word,
	output lane_status_t status
);

	logic tx_rd, tx_rd_mid, tx_rd_next;
	symbol_t tx_enc;
	logic [39:0] window;   // newest symbol in the top half
	logic [4:0] shift_pos, find_pos;
	logic found, aligned, shift_valid;
	symbol_t rx_shift;
	logic rx_rd, rx_rd_mid, rx_rd_next;
	logic [15:0] rx_dec;
	logic [1:0] rx_isk, rx_derr, rx_cerr;

	enc_8b10b u_enc_lo (.din(tx_word.data[7:0]), .isk(tx_word.isk[0]), .rd_in(tx_rd),
		.dout(tx_enc[9:0]), .rd_out(tx_rd_mid));
	enc_8b10b u_enc_hi (.din(tx_word.data[15:8]), .isk(tx_word.isk[1]), .rd_in(tx_rd_mid),
		.dout(tx_enc[19:10]), .rd_out(tx_rd_next));

	always_ff @(posedge TXUSRCLK) begin
		tx_sym <= tx_enc;
		tx_rd  <= sreset ? 1'b0 : tx_rd_next;
	end

	// comma search, lowest offset wins
	always_comb begin
		found    = 1'b0;
		find_pos = '0;
		for (int p = 19; p >= 0; p--) begin
			if (window[p +: 10] == `GTLINK_COMMA) begin
				found    = 1'b1;
				find_pos = 5'(p);
			end
		end
	end

	always_ff @(posedge TXUSRCLK) begin
		if (sreset) begin
			window      <= '0;
			aligned     <= 1'b0;
			shift_pos   <= '0;
			shift_valid <= 1'b0;
		end else begin
			window      <= {rx_sym, window[39:20]};
			shift_valid <= aligned;
			if (!aligned && found) begin // offset is kept once latched
				aligned   <= 1'b1;
				shift_pos <= find_pos;
			end
		end
	end

	always_ff @(posedge TXUSRCLK)
		rx_shift <= 20'(window >> shift_pos);

	dec_8b10b u_dec_lo (.din(rx_shift[9:0]), .rd_in(rx_rd), .dout(rx_dec[7:0]),
		.isk(rx_isk[0]), .rd_out(rx_rd_mid), .disp_err(rx_derr[0]), .code_err(rx_cerr[0]));
	dec_8b10b u_dec_hi (.din(rx_shift[19:10]), .rd_in(rx_rd_mid), .dout(rx_dec[15:8]),
		.isk(rx_isk[1]), .rd_out(rx_rd_next), .disp_err(rx_derr[1]), .code_err(rx_cerr[1]));

	always_ff @(posedge TXUSRCLK) begin
		rx_word.data <= rx_dec;
		rx_word.isk  <= rx_isk;
		if (sreset) begin
			rx_rd         <= 1'b0;
			rx_word.valid <= 1'b0;
			status        <= '0;
		end else begin
			rx_rd           <= shift_valid ? rx_rd_next : 1'b0; // first comma is rd-
			rx_word.valid   <= shift_valid;
			status.aligned  <= aligned;
			status.disp_err <= shift_valid && (|rx_derr);
			status.code_err <= shift_valid && (|rx_cerr);
		end
	end

	a_pos_hold: assert property (@(posedge TXUSRCLK) disable iff (sreset)
		aligned |=> (shift_pos < 5'd20) && $stable(shift_pos));

endmodule

`default_nettype wire

// ==== design/reset_seq.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module reset_seq import gtlink_pkg::*; (
	input  wire        TXUSRCLK,
	input  wire        sreset,
	input  wire        pll_lock,
	input  wire        gt_resetdone,
	output logic       pll_reset,
	output logic       gt_reset,
	output logic       link_up,
	output seq_state_e state
);

	seq_state_e next;
	logic [15:0] cnt;
	logic tmo;

	assign tmo = (cnt == 16'(`GTLINK_TIMEOUT));

	always_comb begin
		next = state;
		case (state)
			IDLE:       next = WAIT_START;
			WAIT_START: next = PLL_RESET;
			PLL_RESET:  if (cnt == 16'(`GTLINK_WAIT_PLL)) next = PLL_WAIT;
			PLL_WAIT:   next = pll_lock ? GT_RESET : (tmo ? WAIT_START : PLL_WAIT);
			GT_RESET:   if (cnt == 16'(`GTLINK_WAIT_GT)) next = GT_WAIT;
			GT_WAIT:    next = gt_resetdone ? DATA : (tmo ? WAIT_START : GT_WAIT);
			DATA:       next = DATA;
			default:    next = IDLE;
		endcase
		// lost lock sends every later state back to the start
		if (!pll_lock && (state == GT_RESET || state == GT_WAIT || state == DATA))
			next = WAIT_START;
	end

	always_ff @(posedge TXUSRCLK) begin
		if (sreset) begin
			state     <= IDLE;
			cnt       <= '0;
			pll_reset <= 1'b1;
			gt_reset  <= 1'b1;
			link_up   <= 1'b0;
		end else begin
			state     <= next;
			cnt       <= (next == state) ? cnt + 16'd1 : 16'd0;
			pll_reset <= (next == IDLE || next == WAIT_START || next == PLL_RESET);
			gt_reset  <= !(next == GT_WAIT || next == DATA);
			link_up   <= (next == DATA);
		end
	end

	// link_up follows a lost lock by one cycle at most
	a_link_lock: assert property (@(posedge TXUSRCLK) disable iff (sreset)
		!pll_lock |=> !link_up);

endmodule

`default_nettype wire

// ==== design/tx_framer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module tx_framer import gtlink_pkg::*; (
	input  wire        TXUSRCLK,
	input  wire        sreset,
	input  wire        link_up,
	input  lane_word_t [`GTLINK_LANES-1:0] user_word,
	output lane_word_t [`GTLINK_LANES-1:0] lane_word
);

	localparam lane_word_t IDLE_WORD = '{
		valid: 1'b0,
		isk:   2'b11,
		data:  {`GTLINK_K28_5, `GTLINK_K28_5}
	};

	always_ff @(posedge TXUSRCLK) begin
		for (int i = 0; i < `GTLINK_LANES; i++) begin
			if (sreset)
				lane_word[i] <= IDLE_WORD;
			else if (link_up && user_word[i].valid)
				lane_word[i] <= user_word[i];
			else
				lane_word[i] <= IDLE_WORD; // fill the empty cycle
		end
	end

endmodule

`default_nettype wire

// ==== design/rx_deframer.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module rx_deframer import gtlink_pkg::*; (
	input  wire          TXUSRCLK,
	input  wire          sreset,
	input  wire          link_up,
	input  lane_word_t   [`GTLINK_LANES-1:0] lane_word,
	input  lane_status_t [`GTLINK_LANES-1:0] lane_status,
	output lane_word_t   [`GTLINK_LANES-1:0] user_word,
	output logic         all_aligned,
	output logic         link_err
);

	logic [`GTLINK_LANES-1:0] is_idle, aligned_v, err_v;

	always_comb begin
		for (int i = 0; i < `GTLINK_LANES; i++) begin
			is_idle[i]   = (lane_word[i].isk == 2'b11) &&
				(lane_word[i].data == {`GTLINK_K28_5, `GTLINK_K28_5});
			aligned_v[i] = lane_status[i].aligned;
			err_v[i]     = lane_status[i].disp_err | lane_status[i].code_err;
		end
	end

	always_ff @(posedge TXUSRCLK) begin
		for (int i = 0; i < `GTLINK_LANES; i++) begin
			user_word[i].data <= lane_word[i].data;
			user_word[i].isk  <= lane_word[i].isk;
		end
		if (sreset) begin
			for (int i = 0; i < `GTLINK_LANES; i++)
				user_word[i].valid <= 1'b0;
			all_aligned <= 1'b0;
			link_err    <= 1'b0;
		end else begin
			for (int i = 0; i < `GTLINK_LANES; i++)
				user_word[i].valid <= lane_word[i].valid && aligned_v[i] && link_up && !is_idle[i];
			all_aligned <= &aligned_v;
			link_err    <= link_err | (|err_v); // sticky
		end
	end

endmodule

`default_nettype wire

// ==== design/link_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module link_top import gtlink_pkg::*; (
	input  wire        TXUSRCLK,
	input  wire        sreset,
	input  wire        pll_lock,
	input  wire        gt_resetdone,
	output logic       pll_reset,
	output logic       gt_reset,
	output logic       link_up,
	input  lane_word_t [`GTLINK_LANES-1:0] tx_word,
	output symbol_t    [`GTLINK_LANES-1:0] tx_sym,
	input  symbol_t    [`GTLINK_LANES-1:0] rx_sym,
	output lane_word_t [`GTLINK_LANES-1:0] rx_word,
	output logic       all_aligned,
	output logic       link_err
);

	lane_word_t   [`GTLINK_LANES-1:0] lane_tx, lane_rx;
	lane_status_t [`GTLINK_LANES-1:0] lane_stat;

	reset_seq u_seq (.TXUSRCLK, .sreset, .pll_lock, .gt_resetdone, .pll_reset, .gt_reset,
		.link_up, .state());

	tx_framer u_framer (.TXUSRCLK, .sreset, .link_up, .user_word(tx_word), .lane_word(lane_tx));

	for (genvar i = 0; i < `GTLINK_LANES; i++) begin : g_lane
		gt_lane u_lane (.TXUSRCLK, .sreset, .tx_word(lane_tx[i]), .tx_sym(tx_sym[i]),
			.rx_sym(rx_sym[i]), .rx_word(lane_rx[i]), .status(lane_stat[i]));
	end

	rx_deframer u_deframer (.TXUSRCLK, .sreset, .link_up, .lane_word(lane_rx),
		.lane_status(lane_stat), .user_word(rx_word), .all_aligned, .link_err);

endmodule

`default_nettype wire

// ==== verif/link_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "gtlink_cfg.svh"

module link_tb import gtlink_pkg::*; ();

	localparam int LANES       = `GTLINK_LANES;
	localparam int WAIT_LIMIT  = 1000; // covers the GT reset hold
	localparam int DRAIN_LIMIT = 200;
	localparam int ERR_LIMIT   = 50;
	localparam int NUM_ROWS    = 5;

	// low byte K28.5 at rd-, high byte K28.5 at rd+, first line bit in bit 0
	localparam symbol_t IDLE_SYM = {10'b1010000011, `GTLINK_COMMA};

	typedef struct packed {
		logic [`GTLINK_LANES-1:0][4:0] slip; // bit slip per lane
		logic       drop_lock;
		logic       corrupt;
		logic [7:0] nwords;  // words per lane
	} test_row_t;

	logic TXUSRCLK;
	logic sreset;
	logic pll_lock;
	logic gt_resetdone;
	logic pll_reset;
	logic gt_reset;
	logic link_up;
	logic all_aligned;
	logic link_err;
	lane_word_t [LANES-1:0] tx_word;
	lane_word_t [LANES-1:0] rx_word;
	symbol_t    [LANES-1:0] tx_sym;
	symbol_t    [LANES-1:0] rx_sym;
	symbol_t    [LANES-1:0] prev_sym;
	symbol_t    [LANES-1:0] flip;    // bits to invert on the line
	logic       [LANES-1:0][4:0] slip;
	logic       ignore_rx;

	test_row_t  rows [NUM_ROWS];
	lane_word_t exp_q [LANES][$];
	lane_word_t exp_w;
	int errors;
	int failed_tests;
	int unsigned seed;

	link_top dut (.TXUSRCLK, .sreset, .pll_lock, .gt_resetdone, .pll_reset, .gt_reset,
		.link_up, .tx_word, .tx_sym, .rx_sym, .rx_word, .all_aligned, .link_err);

	always #20 TXUSRCLK = ~TXUSRCLK;

	// 20 bits of the line stream starting at the slip offset
	function automatic symbol_t slip_sym(input symbol_t cur, input symbol_t prev,
		input logic [4:0] s);
		logic [39:0] both;
		both = {cur, prev}; // prev went out first
		return both[s +: 20];
	endfunction

	// loopback channel
	always @(posedge TXUSRCLK) begin
		for (int i = 0; i < LANES; i++) begin
			rx_sym[i]   <= slip_sym(tx_sym[i] ^ flip[i], prev_sym[i], slip[i]);
			prev_sym[i] <= tx_sym[i] ^ flip[i];
		end
	end

	// in-order compare of received words against the sent queue
	always @(posedge TXUSRCLK) begin
		for (int i = 0; i < LANES; i++) begin
			if (rx_word[i].valid === 1'b1 && !ignore_rx) begin
				if (exp_q[i].size() == 0) begin
					$display("lane %0d delivered word %h with nothing outstanding at %0t",
						i, rx_word[i].data, $time);
					errors++;
				end else begin
					exp_w = exp_q[i].pop_front();
					if (rx_word[i].data !== exp_w.data) begin
						$display("MISMATCH t=%0t rx_word[%0d].data expected %h got %h",
							$time, i, exp_w.data, rx_word[i].data);
						errors++;
					end
					if (rx_word[i].isk !== exp_w.isk) begin
						$display("MISMATCH t=%0t rx_word[%0d].isk expected %b got %b",
							$time, i, exp_w.isk, rx_word[i].isk);
						errors++;
					end
				end
			end
		end
	end

	function automatic int outstanding();
		int total;
		total = 0;
		for (int i = 0; i < LANES; i++)
			total += exp_q[i].size();
		return total;
	endfunction

	// valid word, sometimes with K28.5 in one byte
	function automatic lane_word_t random_word();
		lane_word_t w;
		w.valid = 1'b1;
		w.isk   = 2'b00;
		w.data  = 16'($urandom);
		case ($urandom_range(3))
			1: begin
				w.isk       = 2'b01;
				w.data[7:0] = `GTLINK_K28_5;
			end
			2: begin
				w.isk        = 2'b10;
				w.data[15:8] = `GTLINK_K28_5;
			end
			default: ;
		endcase
		return w;
	endfunction

	task automatic wait_link(input logic level);
		int n;
		n = 0;
		while (link_up !== level && n < WAIT_LIMIT) begin
			@(posedge TXUSRCLK);
			n++;
		end
		if (link_up !== level) begin
			$display("link_up did not go to %0b within %0d cycles at %0t",
				level, WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	// transceiver model: lock right away, resetdone once gt_reset drops
	task automatic bring_up();
		int n;
		pll_lock <= 1'b1;
		n = 0;
		while (gt_reset !== 1'b0 && n < WAIT_LIMIT) begin
			@(posedge TXUSRCLK);
			n++;
		end
		if (gt_reset !== 1'b0) begin
			$display("gt_reset was never released within %0d cycles at %0t", WAIT_LIMIT, $time);
			errors++;
		end
		gt_resetdone <= 1'b1;
		wait_link(1'b1);
	endtask

	task automatic wait_aligned();
		int n;
		n = 0;
		while (all_aligned !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge TXUSRCLK);
			n++;
		end
		if (all_aligned !== 1'b1) begin
			$display("lanes did not all align within %0d cycles at %0t", WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	task automatic wait_drain();
		int n;
		int left;
		n    = 0;
		left = outstanding();
		while (left != 0 && n < DRAIN_LIMIT) begin
			@(posedge TXUSRCLK);
			n++;
			left = outstanding();
		end
		if (left != 0) begin
			$display("%0d sent words never arrived within %0d cycles at %0t",
				left, DRAIN_LIMIT, $time);
			errors++;
		end
	endtask

	task automatic wait_link_err();
		int n;
		n = 0;
		while (link_err !== 1'b1 && n < ERR_LIMIT) begin
			@(posedge TXUSRCLK);
			n++;
		end
		if (link_err !== 1'b1) begin
			$display("link_err stayed low after a corrupted symbol at %0t", $time);
			errors++;
		end
	endtask

	task automatic send_words(input int n);
		lane_word_t w;
		for (int k = 0; k < n; k++) begin
			@(posedge TXUSRCLK);
			for (int i = 0; i < LANES; i++) begin
				w = random_word();
				tx_word[i] <= w;
				exp_q[i].push_back(w);
			end
			if ($urandom_range(3) == 0) begin // idle gap, junk data
				@(posedge TXUSRCLK);
				for (int i = 0; i < LANES; i++)
					tx_word[i] <= {1'b0, 18'($urandom)};
			end
		end
		@(posedge TXUSRCLK);
		tx_word <= '0;
	endtask

	task automatic run_test(input int idx, input test_row_t r);
		int errs_at_start;
		errs_at_start = errors;
		@(posedge TXUSRCLK);
		sreset       <= 1'b1;
		pll_lock     <= 1'b0;
		gt_resetdone <= 1'b0;
		tx_word      <= '0;
		flip         <= '0;
		ignore_rx    <= 1'b0;
		slip         <= r.slip;
		for (int i = 0; i < LANES; i++)
			exp_q[i].delete();
		repeat (10) @(posedge TXUSRCLK);
		// still in reset here
		if (link_up !== 1'b0) begin
			$display("MISMATCH t=%0t link_up expected 0 got %b", $time, link_up);
			errors++;
		end
		if (pll_reset !== 1'b1) begin
			$display("MISMATCH t=%0t pll_reset expected 1 got %b", $time, pll_reset);
			errors++;
		end
		if (gt_reset !== 1'b1) begin
			$display("MISMATCH t=%0t gt_reset expected 1 got %b", $time, gt_reset);
			errors++;
		end
		for (int i = 0; i < LANES; i++) begin
			if (rx_word[i].valid !== 1'b0) begin
				$display("MISMATCH t=%0t rx_word[%0d].valid expected 0 got %b",
					$time, i, rx_word[i].valid);
				errors++;
			end
			if (tx_sym[i] !== IDLE_SYM) begin
				$display("MISMATCH t=%0t tx_sym[%0d] expected %h got %h",
					$time, i, IDLE_SYM, tx_sym[i]);
				errors++;
			end
		end
		sreset <= 1'b0;
		bring_up();
		wait_aligned();
		send_words(r.nwords);
		wait_drain();
		if (r.drop_lock) begin
			pll_lock     <= 1'b0;
			gt_resetdone <= 1'b0;
			wait_link(1'b0);
			repeat (20) begin
				@(posedge TXUSRCLK);
				for (int i = 0; i < LANES; i++) begin
					tx_word[i] <= random_word(); // held back while the link is down
					if (rx_word[i].valid === 1'b1) begin
						$display("lane %0d delivered a word while the link was down at %0t",
							i, $time);
						errors++;
					end
				end
			end
			@(posedge TXUSRCLK);
			tx_word <= '0;
			bring_up();
			send_words(r.nwords);
			wait_drain();
		end
		if (r.corrupt) begin
			ignore_rx <= 1'b1; // the broken idle may decode as data
			@(posedge TXUSRCLK);
			flip[0] <= 20'h00001;
			@(posedge TXUSRCLK);
			flip[0] <= '0;
			wait_link_err();
		end else if (link_err !== 1'b0) begin
			$display("MISMATCH t=%0t link_err expected 0 got %b", $time, link_err);
			errors++;
		end
		if (errors != errs_at_start)
			failed_tests++;
		$display("test %0d: slip %0d/%0d, lock drop %0b, corrupt %0b, %0d words: %s",
			idx, r.slip[0], r.slip[1], r.drop_lock, r.corrupt, r.nwords,
			(errors == errs_at_start) ? "ok" : "errors");
	endtask

	initial begin
		seed = 32'h3ba8;
		void'($urandom(seed));
		TXUSRCLK     = 1'b0;
		sreset       = 1'b1;
		pll_lock     = 1'b0;
		gt_resetdone = 1'b0;
		tx_word      = '0;
		rx_sym       = '0;
		prev_sym     = '0;
		flip         = '0;
		slip         = '0;
		ignore_rx    = 1'b0;
		errors       = 0;
		failed_tests = 0;
		rows[0] = '{slip: {5'd0, 5'd0}, drop_lock: 1'b0, corrupt: 1'b0, nwords: 8'd40};
		rows[1] = '{slip: {5'd19, 5'd7}, drop_lock: 1'b0, corrupt: 1'b0, nwords: 8'd40};
		rows[2] = '{slip: {5'd7, 5'd19}, drop_lock: 1'b0, corrupt: 1'b0, nwords: 8'd40};
		rows[3] = '{slip: {5'd12, 5'd3}, drop_lock: 1'b1, corrupt: 1'b0, nwords: 8'd30};
		rows[4] = '{slip: {5'd0, 5'd7}, drop_lock: 1'b0, corrupt: 1'b1, nwords: 8'd20};
		for (int t = 0; t < NUM_ROWS; t++)
			run_test(t, rows[t]);
		$display("%0d tests run, %0d failed, %0d errors", NUM_ROWS, failed_tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/gtlink_pkg.sv
lane/enc_8b10b.sv
lane/dec_8b10b.sv
lane/gt_lane.sv
design/reset_seq.sv
design/tx_framer.sv
design/rx_deframer.sv
design/link_top.sv
verif/link_tb.sv

// ==== Bender.yml ====
package:
  name: gtlink

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/gtlink_pkg.sv
      - lane/enc_8b10b.sv
      - lane/dec_8b10b.sv
      - lane/gt_lane.sv
      - design/reset_seq.sv
      - design/tx_framer.sv
      - design/rx_deframer.sv
      - design/link_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/link_tb.sv
